//--- common/lsu_cfg_pkg.sv
package lsu_cfg_pkg;

   // Core data path
   localparam int data_w = 32;
   localparam int addr_w = 32;

   // Byte lanes of one bus word
   localparam int bytes_w = data_w / 8;
   localparam int off_w = $clog2(bytes_w);  // Byte offset inside a word

   // Lane widths used by the aligners
   localparam int byte_w = 8;
   localparam int half_w = 16;

endpackage

//--- common/lsu_op_pkg.sv
package lsu_op_pkg;

   // Opcode bus from the commit stage
   localparam int opc_w = 5;

   localparam int opc_load_bit = 0;   // Load request
   localparam int opc_store_bit = 1;  // Store request
   localparam int opc_sext_bit = 2;   // Sign extend the load result
   localparam int opc_size_lsb = 3;   // Start of the size field

   // Width of the size field
   localparam int size_w = 2;

   // Access size, value 3 unused
   typedef enum logic [size_w-1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } lsu_size_e;

endpackage

//--- common/lsu_op_if.sv
interface lsu_op_if;
   import lsu_cfg_pkg::*;
   import lsu_op_pkg::*;

   logic [off_w-1:0] off;  // Byte offset of the held request
   lsu_size_e size;
   logic sext;
   logic ld;
   logic cap;              // Read data valid, register it

   modport ctrl (
      output off,
      output size,
      output sext,
      output ld,
      output cap
   );

   modport load (
      input off,
      input size,
      input sext,
      input ld,
      input cap
   );

endinterface

//--- hdl/lsu_store_align.sv
module lsu_store_align (
   input  logic [lsu_cfg_pkg::addr_w-1:0]  lsa,
   input  logic [lsu_cfg_pkg::data_w-1:0]  wdat,
   input  logic [lsu_op_pkg::opc_w-1:0]    opc,
   output logic                            misalign,
   output logic [lsu_cfg_pkg::data_w-1:0]  st_data,
   output logic [lsu_cfg_pkg::bytes_w-1:0] st_sel
);
   import lsu_cfg_pkg::*;
   import lsu_op_pkg::*;

   lsu_size_e size;
   logic [off_w-1:0] off;
   logic req;
   logic [2:0] exp_bytes;

   assign size = lsu_size_e'(opc[opc_size_lsb +: size_w]);
   assign off = lsa[off_w-1:0];
   assign req = opc[opc_load_bit] | opc[opc_store_bit];

   // Bytes can sit anywhere
   assign misalign = ((size == size_half) & off[0]) |
                     ((size == size_word) & (|off));

   always_comb begin
      case (size)
         size_byte: begin
            st_data = {bytes_w{wdat[byte_w-1:0]}};  // Same byte on every lane
            st_sel = bytes_w'(1) << off;
         end
         size_half: begin
            st_data = {(data_w / half_w){wdat[half_w-1:0]}};
            st_sel = off[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            st_data = wdat;
            st_sel = '1;
         end
      endcase
   end

   assign exp_bytes = (size == size_byte) ? 3'd1 :
                      (size == size_half) ? 3'd2 : 3'd4;

   // Lane count of an aligned access matches its size
   a_sel_count: assert final (!req || misalign || $countones(st_sel) == exp_bytes);

endmodule

//--- hdl/lsu_ctrl.sv
module lsu_ctrl (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            req_valid,
   input  logic [lsu_op_pkg::opc_w-1:0]    opc,
   input  logic [lsu_cfg_pkg::addr_w-1:0]  lsa,
   input  logic                            misalign,
   input  logic [lsu_cfg_pkg::data_w-1:0]  st_data,
   input  logic [lsu_cfg_pkg::bytes_w-1:0] st_sel,
   input  logic                            wb_ack,
   output logic                            stall_req,
   output logic                            wb_valid,
   output logic                            ealign,
   output logic [lsu_cfg_pkg::addr_w-1:0]  vaddr,
   output logic                            wb_cyc,
   output logic                            wb_stb,
   output logic                            wb_we,
   output logic [lsu_cfg_pkg::addr_w-1:0]  wb_adr,
   output logic [lsu_cfg_pkg::bytes_w-1:0] wb_sel,
   output logic [lsu_cfg_pkg::data_w-1:0]  wb_wdat,
   lsu_op_if.ctrl                          op
);
   import lsu_cfg_pkg::*;
   import lsu_op_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_bus,   // Wishbone cycle open
      st_done   // Writeback, or alignment fault
   } state_e;

   state_e state, state_nxt;

   logic req_ld;
   logic req_st;
   logic accept;

   // Held request
   logic [addr_w-1:0] adr_q;
   logic [data_w-1:0] wdat_q;
   logic [bytes_w-1:0] sel_q;
   lsu_size_e size_q;
   logic sext_q;
   logic ld_q;
   logic mis_q;

   assign req_ld = opc[opc_load_bit];
   assign req_st = opc[opc_store_bit];
   assign accept = req_valid & ~stall_req & (req_ld | req_st);  // No-op opcodes dropped

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle, st_done: begin
            if (accept) begin
               state_nxt = misalign ? st_done : st_bus;  // Fault skips the bus
            end else begin
               state_nxt = st_idle;
            end
         end
         st_bus: begin
            if (wb_ack) begin
               state_nxt = st_done;
            end
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         adr_q <= lsa;
         wdat_q <= st_data;
         sel_q <= req_ld ? '1 : st_sel;  // Loads read the whole word
         size_q <= lsu_size_e'(opc[opc_size_lsb +: size_w]);
         sext_q <= opc[opc_sext_bit];
         ld_q <= req_ld;
         mis_q <= misalign;
      end
   end

   // Wishbone classic master
   assign wb_cyc = (state == st_bus);
   assign wb_stb = (state == st_bus);
   assign wb_we = ~ld_q;
   assign wb_adr = {adr_q[addr_w-1:off_w], {off_w{1'b0}}};  // Word address
   assign wb_sel = sel_q;
   assign wb_wdat = wdat_q;

   // Back to the core
   assign wb_valid = (state == st_done);
   assign ealign = wb_valid & mis_q;
   assign stall_req = wb_cyc | ealign;
   assign vaddr = adr_q;

   // Held operation for the load path
   assign op.off = adr_q[off_w-1:0];
   assign op.size = size_q;
   assign op.sext = sext_q;
   assign op.ld = ld_q;
   assign op.cap = wb_cyc & wb_ack & ld_q;

   a_stb_cyc: assert property (
      @(posedge clk) disable iff (rst) wb_stb |-> wb_cyc
   );

   // Request must not move while the slave is still waiting
   a_req_hold: assert property (
      @(posedge clk) disable iff (rst)
      wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_sel)
   );

   a_ealign_no_bus: assert property (
      @(posedge clk) disable iff (rst) !(ealign && wb_cyc)
   );

endmodule

//--- hdl/lsu_load_align.sv
module lsu_load_align (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [lsu_cfg_pkg::data_w-1:0] wb_rdat,
   output logic [lsu_cfg_pkg::data_w-1:0] dout,
   lsu_op_if.load                         op
);
   import lsu_cfg_pkg::*;
   import lsu_op_pkg::*;

   logic [byte_w-1:0] lane_b;
   logic [half_w-1:0] lane_h;
   logic [data_w-1:0] ext;

   assign lane_b = wb_rdat[op.off * byte_w +: byte_w];  // Lane named by the offset
   assign lane_h = op.off[1] ? wb_rdat[data_w-1:half_w] : wb_rdat[half_w-1:0];

   always_comb begin
      case (op.size)
         size_byte: begin
            ext = {{(data_w - byte_w){op.sext & lane_b[byte_w-1]}}, lane_b};
         end
         size_half: begin
            ext = {{(data_w - half_w){op.sext & lane_h[half_w-1]}}, lane_h};
         end
         default: begin
            ext = wb_rdat;
         end
      endcase
   end

   // Result holds until the next load returns
   always_ff @(posedge clk) begin
      if (rst) begin
         dout <= '0;
      end else if (op.cap) begin
         dout <= ext;
      end
   end

   // Stores never overwrite the load result
   a_cap_load_only: assert property (
      @(posedge clk) disable iff (rst) op.cap |-> op.ld
   );

endmodule

//--- hdl/lsu_top.sv
module lsu_top (
   input  logic                            clk,
   input  logic                            rst,
   // Commit stage request
   input  logic                            req_valid,
   input  logic [lsu_op_pkg::opc_w-1:0]    opc,
   input  logic [lsu_cfg_pkg::addr_w-1:0]  lsa,
   input  logic [lsu_cfg_pkg::data_w-1:0]  wdat,
   // Writeback side
   output logic                            stall_req,
   output logic                            wb_valid,
   output logic [lsu_cfg_pkg::data_w-1:0]  dout,
   output logic                            ealign,
   output logic [lsu_cfg_pkg::addr_w-1:0]  vaddr,
   // Wishbone data port
   output logic                            wb_cyc,
   output logic                            wb_stb,
   output logic                            wb_we,
   output logic [lsu_cfg_pkg::addr_w-1:0]  wb_adr,
   output logic [lsu_cfg_pkg::bytes_w-1:0] wb_sel,
   output logic [lsu_cfg_pkg::data_w-1:0]  wb_wdat,
   input  logic [lsu_cfg_pkg::data_w-1:0]  wb_rdat,
   input  logic                            wb_ack
);
   import lsu_cfg_pkg::*;

   logic misalign;
   logic [data_w-1:0] st_data;
   logic [bytes_w-1:0] st_sel;

   lsu_op_if op_if ();

   lsu_store_align u_store_align (
      .lsa      (lsa),
      .wdat     (wdat),
      .opc      (opc),
      .misalign (misalign),
      .st_data  (st_data),
      .st_sel   (st_sel)
   );

   lsu_ctrl u_ctrl (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .opc       (opc),
      .lsa       (lsa),
      .misalign  (misalign),
      .st_data   (st_data),
      .st_sel    (st_sel),
      .wb_ack    (wb_ack),
      .stall_req (stall_req),
      .wb_valid  (wb_valid),
      .ealign    (ealign),
      .vaddr     (vaddr),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_sel    (wb_sel),
      .wb_wdat   (wb_wdat),
      .op        (op_if.ctrl)
   );

   lsu_load_align u_load_align (
      .clk     (clk),
      .rst     (rst),
      .wb_rdat (wb_rdat),
      .dout    (dout),
      .op      (op_if.load)
   );

endmodule

//--- dv/wb_mem_model.sv
module wb_mem_model (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            wb_cyc,
   input  logic                            wb_stb,
   input  logic                            wb_we,
   input  logic [lsu_cfg_pkg::addr_w-1:0]  wb_adr,
   input  logic [lsu_cfg_pkg::bytes_w-1:0] wb_sel,
   input  logic [lsu_cfg_pkg::data_w-1:0]  wb_wdat,
   output logic [lsu_cfg_pkg::data_w-1:0]  wb_rdat,
   output logic                            wb_ack
);
   timeunit 1ns;
   timeprecision 1ps;
   import lsu_cfg_pkg::*;

   localparam int depth = 256;
   localparam int idx_w = 8;

   logic [data_w-1:0] mem [depth];
   logic [idx_w-1:0] idx;
   logic busy;       // Request seen, wait cycles running
   int wait_cnt;

   assign idx = wb_adr[off_w +: idx_w];

   initial begin
      wb_ack = 1'b0;
      wb_rdat = '0;
      // Every bit of the word index shows up in the fill word
      for (int i = 0; i < depth; i++) begin
         mem[i] = {8'(i) ^ 8'hc5, ~8'(i), 8'(i) ^ 8'h3a, 8'(i)};
      end
   end

   always @(posedge clk) begin : slave
      int delay;
      if (rst) begin
         wb_ack <= 1'b0;
         wb_rdat <= '0;
         busy <= 1'b0;
         wait_cnt <= 0;
      end else begin
         wb_ack <= 1'b0;
         if (wb_cyc && wb_stb && !wb_ack) begin
            delay = busy ? wait_cnt : $urandom_range(3, 0);  // 0 to 3 wait cycles
            if (delay == 0) begin
               busy <= 1'b0;
               wb_ack <= 1'b1;
               wb_rdat <= mem[idx];
               for (int i = 0; i < bytes_w; i++) begin
                  if (wb_we && wb_sel[i]) begin
                     mem[idx][8*i +: 8] <= wb_wdat[8*i +: 8];
                  end
               end
            end else begin
               busy <= 1'b1;
               wait_cnt <= delay - 1;
            end
         end
      end
   end

endmodule

//--- dv/lsu_tb.sv
module lsu_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import lsu_cfg_pkg::*;
   import lsu_op_pkg::*;

   localparam int reset_cycles = 8;
   localparam int n_directed = 22;
   localparam int n_random = 40;
   localparam int n_ops = n_directed + n_random;

   typedef struct packed {
      int idx;                   // Position in op_names
      logic ld;
      logic mis;
      logic [addr_w-1:0] addr;
      logic [bytes_w-1:0] sel;
      logic [data_w-1:0] wdat;
      logic [data_w-1:0] dout;
   } expect_t;

   logic clk;
   logic rst;
   logic req_valid;
   logic [opc_w-1:0] opc;
   logic [addr_w-1:0] lsa;
   logic [data_w-1:0] wdat;
   logic stall_req;
   logic wb_valid;
   logic [data_w-1:0] dout;
   logic ealign;
   logic [addr_w-1:0] vaddr;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   logic [addr_w-1:0] wb_adr;
   logic [bytes_w-1:0] wb_sel;
   logic [data_w-1:0] wb_wdat;
   logic [data_w-1:0] wb_rdat;
   logic wb_ack;

   logic [7:0] ref_mem [1024];  // Byte image of the slave memory
   string op_names[$];
   expect_t cur;                // Request on the inputs now
   expect_t exp_q;              // Request accepted last
   logic acc;
   bit started = 0;
   int errors = 0;
   int outstanding = 0;

   lsu_top lsu_top_i (.*);
   wb_mem_model mem_i (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [opc_w-1:0] make_opc(bit ld, bit sx, lsu_size_e sz);
      logic [opc_w-1:0] o;
      o = '0;
      o[opc_load_bit] = ld;
      o[opc_store_bit] = !ld;
      o[opc_sext_bit] = sx;
      o[opc_size_lsb +: size_w] = sz;
      return o;
   endfunction

   // Keep the low bits, fill the rest with zeros or the sign
   function automatic logic [data_w-1:0] extend(logic [data_w-1:0] v, int bits, bit sx);
      logic [data_w-1:0] mask;
      mask = (bits >= data_w) ? '1 : (data_w'(1) << bits) - 1;
      v = v & mask;
      if (sx && v[bits-1]) begin
         v = v | ~mask;
      end
      return v;
   endfunction

   task automatic report_mismatch(int idx, string what, logic [data_w-1:0] e,
                                  logic [data_w-1:0] a);
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", op_names[idx], what, e, a);
   endtask

   task automatic report_fail(string msg);
      errors++;
      $display("error: %s", msg);
   endtask

   // Entered and left 2 ns after a rising edge
   task automatic run_op(string name, bit ld, bit sx, lsu_size_e sz,
                         logic [addr_w-1:0] a, logic [data_w-1:0] d);
      int base;
      int nbytes;
      logic [data_w-1:0] word;
      base = int'({a[9:2], 2'b00});
      nbytes = (sz == size_byte) ? 1 : (sz == size_half) ? 2 : 4;
      word = {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
      cur.idx = op_names.size();
      cur.ld = ld;
      cur.mis = (a[1:0] % nbytes) != 0;
      cur.addr = a;
      cur.sel = ld ? '1 : bytes_w'(((1 << nbytes) - 1) << a[1:0]);
      cur.wdat = (sz == size_byte) ? {4{d[7:0]}} : (sz == size_half) ? {2{d[15:0]}} : d;
      cur.dout = extend(word >> (8 * a[1:0]), 8 * nbytes, sx);
      if (!ld && !cur.mis) begin
         for (int i = 0; i < bytes_w; i++) begin
            if (cur.sel[i]) begin
               ref_mem[base + i] = cur.wdat[8*i +: 8];
            end
         end
      end
      while (stall_req) begin
         @(posedge clk);
         #2;
      end
      op_names.push_back(name);
      started = 1;
      req_valid = 1'b1;
      opc = make_opc(ld, sx, sz);
      lsa = a;
      wdat = d;
      @(posedge clk);
      #2;
      req_valid = 1'b0;
      opc = '0;
      while (!wb_valid) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic run_noop();
      while (stall_req) begin
         @(posedge clk);
         #2;
      end
      started = 1;
      req_valid = 1'b1;
      opc = '0;
      opc[opc_sext_bit] = 1'b1;  // Neither load nor store
      @(posedge clk);
      #2;
      req_valid = 1'b0;
   endtask

   assign acc = req_valid && !stall_req && (opc[opc_load_bit] || opc[opc_store_bit]);

   always @(posedge clk) begin
      if (acc) begin
         exp_q <= cur;
      end
      if (rst) begin
         outstanding <= 0;
      end else begin
         outstanding <= outstanding + int'(acc) - int'(wb_valid);
      end
   end

   a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
      !started |-> !(wb_cyc || wb_stb || stall_req || wb_valid || ealign))
      else report_fail("outputs active before the first request");
   a_noop_ignored: assert property (@(posedge clk) disable iff (rst)
      req_valid && !stall_req && !acc |=> !stall_req && !wb_cyc && !wb_valid)
      else report_fail("request without load or store flag was not ignored");
   a_bus_start: assert property (@(posedge clk) disable iff (rst)
      acc && !cur.mis |=> wb_cyc && wb_stb && stall_req)
      else report_fail("aligned request opened no bus cycle in the next cycle");
   a_misalign_fault: assert property (@(posedge clk) disable iff (rst)
      acc && cur.mis |=> wb_valid && ealign && !wb_cyc)
      else report_fail("misaligned request gave no fault, or started a bus cycle");
   a_bus_adr: assert property (@(posedge clk) disable iff (rst)
      wb_stb |-> wb_adr == (exp_q.addr & ~32'h3))
      else report_mismatch($sampled(exp_q.idx), "wb_adr", $sampled(exp_q.addr) & ~32'h3,
                           $sampled(wb_adr));
   a_bus_sel: assert property (@(posedge clk) disable iff (rst)
      wb_stb |-> wb_sel == exp_q.sel)
      else report_mismatch($sampled(exp_q.idx), "wb_sel", $sampled(exp_q.sel), $sampled(wb_sel));
   a_bus_we: assert property (@(posedge clk) disable iff (rst)
      wb_stb |-> wb_we == !exp_q.ld)
      else report_mismatch($sampled(exp_q.idx), "wb_we", !$sampled(exp_q.ld),
                           $sampled(wb_we));
   a_bus_wdat: assert property (@(posedge clk) disable iff (rst)
      wb_stb && !exp_q.ld |-> wb_wdat == exp_q.wdat)
      else report_mismatch($sampled(exp_q.idx), "wb_wdat", $sampled(exp_q.wdat),
                           $sampled(wb_wdat));
   a_bus_stable: assert property (@(posedge clk) disable iff (rst)
      wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_sel) && $stable(wb_wdat))
      else report_fail("bus request changed before ack");
   a_stall_on_bus: assert property (@(posedge clk) disable iff (rst) wb_cyc |-> stall_req)
      else report_fail("stall low during a bus cycle");
   a_valid_after_ack: assert property (@(posedge clk) disable iff (rst)
      wb_ack |=> wb_valid && !stall_req)
      else report_fail("no writeback in the cycle after ack, or stall still high");
   a_one_result: assert property (@(posedge clk) disable iff (rst)
      wb_valid |-> outstanding == 1 && ($past(wb_ack) || ealign))
      else report_fail("writeback valid without a matching accepted request");
   a_ealign: assert property (@(posedge clk) disable iff (rst) wb_valid |-> ealign == exp_q.mis)
      else report_mismatch($sampled(exp_q.idx), "ealign", $sampled(exp_q.mis), $sampled(ealign));
   a_vaddr: assert property (@(posedge clk) disable iff (rst) wb_valid |-> vaddr == exp_q.addr)
      else report_mismatch($sampled(exp_q.idx), "vaddr", $sampled(exp_q.addr), $sampled(vaddr));
   a_load_data: assert property (@(posedge clk) disable iff (rst)
      wb_valid && exp_q.ld && !exp_q.mis |-> dout == exp_q.dout)
      else report_mismatch($sampled(exp_q.idx), "dout", $sampled(exp_q.dout), $sampled(dout));

   initial begin : stimulus
      lsu_size_e sz;
      logic [addr_w-1:0] a;
      bit ld;
      void'($urandom(40));
      rst = 1'b1;
      req_valid = 1'b0;
      opc = '0;
      lsa = '0;
      wdat = '0;
      repeat (reset_cycles) @(posedge clk);
      #2;
      rst = 1'b0;
      for (int w = 0; w < 256; w++) begin
         {ref_mem[4*w+3], ref_mem[4*w+2], ref_mem[4*w+1], ref_mem[4*w]} = mem_i.mem[w];
      end

      run_op("word_store", 0, 0, size_word, 32'h10, 32'hdeadbeef);
      run_op("word_load", 1, 0, size_word, 32'h10, 0);
      for (int i = 0; i < 4; i++) begin
         run_op($sformatf("byte_store_off%0d", i), 0, 0, size_byte, 32'h20 + i,
                32'hf4338211 >> (8 * i));
      end
      run_op("byte_lanes_load", 1, 0, size_word, 32'h20, 0);
      run_op("half_store_low", 0, 0, size_half, 32'h30, 32'h5555_8765);
      run_op("half_store_high", 0, 0, size_half, 32'h32, 32'h0000_9abc);
      run_op("half_lanes_load", 1, 0, size_word, 32'h30, 0);
      run_op("byte_load_sext", 1, 1, size_byte, 32'h21, 0);
      run_op("byte_load_zext", 1, 0, size_byte, 32'h21, 0);
      run_op("byte_load_sext_top", 1, 1, size_byte, 32'h23, 0);
      run_op("half_load_sext", 1, 1, size_half, 32'h30, 0);
      run_op("half_load_zext", 1, 0, size_half, 32'h32, 0);
      run_op("half_load_sext_top", 1, 1, size_half, 32'h32, 0);
      run_op("half_store_odd", 0, 0, size_half, 32'h31, 32'hffff_ffff);
      run_op("word_store_off2", 0, 0, size_word, 32'h12, 32'hffff_ffff);
      run_op("word_load_off3", 1, 0, size_word, 32'h13, 0);
      run_op("word_unchanged", 1, 0, size_word, 32'h10, 0);
      run_op("halves_unchanged", 1, 0, size_word, 32'h30, 0);
      run_noop();

      for (int i = 0; i < n_random; i++) begin
         ld = $urandom_range(1, 0);
         sz = lsu_size_e'($urandom_range(2, 0));
         a = $urandom_range(1023, 0);
         if ($urandom_range(7, 0) != 0) begin
            a = a & ~((32'h1 << sz) - 1);  // Mostly aligned, a few faults left in
         end
         run_op($sformatf("random_%0d", i), ld, $urandom_range(1, 0), sz, a, $urandom());
      end
      repeat (2) @(posedge clk);

      a_all_done: assert (outstanding == 0)
         else report_fail("accepted request ended without a writeback");
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (reset_cycles + n_ops * 10) @(posedge clk);
      $display("timeout: operations did not finish within %0d cycles", n_ops * 10);
      $display("errors: %0d", errors);
      $display("Some tests failed");
      $finish;
   end

endmodule

//--- tb.f
common/lsu_cfg_pkg.sv
common/lsu_op_pkg.sv
common/lsu_op_if.sv
hdl/lsu_store_align.sv
hdl/lsu_ctrl.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
dv/wb_mem_model.sv
dv/lsu_tb.sv
